// ==== Makefile ====
# Verilator build and run of the audio channel testbench.
# The run passes only when the log holds the pass line.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 \
		-f audio_channel.f --top-module audio_channel_tb \
		-Mdir obj_dir -o audio_channel_sim
	./obj_dir/audio_channel_sim | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== audio_channel.f ====
+incdir+verilog
verilog/audio_channel_pkg.sv
verilog/audio_cmd_queue.sv
verilog/audio_sample_fetcher.sv
verilog/audio_sample_fifo.sv
verilog/audio_sample_output.sv
verilog/audio_channel.sv
tests/audio_bus_model.sv
tests/audio_channel_tb.sv

// ==== tests/audio_bus_model.sv ====
// ======================================================================
// Memory responder for the DMA request/ready bus, for simulation only.
// Ready follows a request after 0 to 3 random cycles. The word
// returned is {address[15:0] + 1, address[15:0]}; there is no storage.
// ======================================================================

`timescale 1ns/1ps

`include "audio_channel_settings.svh"

module audio_bus_model (
	input  logic                             i_clock,
	input  logic                             i_arst_n,
	input  logic                             i_request,
	input  logic [`AUDIO_ADDR_WIDTH-1:0]     i_address,
	output logic                             o_ready,
	output logic [2*`AUDIO_SAMPLE_WIDTH-1:0] o_rdata
);
	logic                             ready_q   = 1'b0;
	logic [2*`AUDIO_SAMPLE_WIDTH-1:0] rdata_q   = '0;
	logic                             armed     = 1'b0;
	int unsigned                      wait_left = 0;

	assign o_ready = ready_q;
	assign o_rdata = rdata_q;

	function automatic logic [31:0] word_for(input logic [`AUDIO_ADDR_WIDTH-1:0] address);
		word_for = {address[15:0] + 16'd1, address[15:0]};
	endfunction

	// Responses change on the falling edge only.
	always @(negedge i_clock) begin : respond
		int unsigned delay;
		if (!i_arst_n || !i_request) begin
			ready_q <= 1'b0;
			armed   <= 1'b0;
		end else if (!armed) begin
			// New request, so pick its latency.
			delay     = $urandom_range(3, 0);
			armed     <= 1'b1;
			wait_left <= delay;
			if (delay == 0) begin
				ready_q <= 1'b1;
				rdata_q <= word_for(i_address);
			end
		end else if (!ready_q) begin
			if (wait_left == 1) begin
				ready_q <= 1'b1;
				rdata_q <= word_for(i_address);
			end
			wait_left <= wait_left - 1;
		end
	end

endmodule

// ==== tests/audio_channel_tb.sv ====
// ======================================================================
// Testbench for the audio playback channel.
// A reference model follows the accepted bus beats and the sample
// clock; concurrent assertions compare the DUT against it.
// ======================================================================

`timescale 1ns/1ps

`include "audio_channel_settings.svh"

module audio_channel_tb;
	import audio_channel_pkg::*;

	localparam int SW             = `AUDIO_SAMPLE_WIDTH;
	localparam int AW             = `AUDIO_ADDR_WIDTH;
	localparam int CW             = `AUDIO_COUNT_WIDTH;
	localparam int TOGGLE_CYCLES  = 12;
	localparam int RESET_CYCLES   = 4;
	// About 60 pairs at 12 cycles each plus idle gaps, with wide margin.
	localparam int TIMEOUT_CYCLES = 20000;

	typedef struct packed {
		sample_format_e format;
		logic [AW-1:0]  address;
		logic [CW-1:0]  count;
	} command_t;

	logic            clock;
	logic            arst_n;
	logic            setup_request;
	setup_mode_e     setup_mode;
	sample_format_e  setup_format;
	logic [AW-1:0]   setup_address;
	logic [CW-1:0]   setup_count;
	logic            dma_request;
	logic [AW-1:0]   dma_address;
	logic            dma_ready;
	logic [2*SW-1:0] dma_rdata;
	logic            busy;
	logic            sample_clock;
	logic [SW-1:0]   sample_left;
	logic [SW-1:0]   sample_right;

	// Reference model state.
	command_t        cmd_q[$];
	logic [2*SW-1:0] pair_q[$];
	sample_format_e  cur_format;
	logic [AW-1:0]   cur_address;
	logic [CW-1:0]   cur_count;
	logic [1:0]      toggle_delay;
	logic            sample_level;
	logic            output_due;
	logic [SW-1:0]   expect_left;
	logic [SW-1:0]   expect_right;
	logic            model_busy;
	logic [AW-1:0]   model_next_address;

	int cycle_count     = 0;
	int beats           = 0;
	int pairs_played    = 0;
	int underruns       = 0;
	int error_count     = 0;
	int errors_at_start = 0;
	int tests_run       = 0;

	logic beat;
	logic replace_now;

	audio_channel dut (
		.i_clock         (clock),
		.i_arst_n        (arst_n),
		.i_setup_request (setup_request),
		.i_setup_mode    (setup_mode),
		.i_setup_format  (setup_format),
		.i_setup_address (setup_address),
		.i_setup_count   (setup_count),
		.o_dma_request   (dma_request),
		.o_dma_address   (dma_address),
		.i_dma_ready     (dma_ready),
		.i_dma_rdata     (dma_rdata),
		.o_busy          (busy),
		.i_sample_clock  (sample_clock),
		.o_sample_left   (sample_left),
		.o_sample_right  (sample_right)
	);

	audio_bus_model bus (
		.i_clock   (clock),
		.i_arst_n  (arst_n),
		.i_request (dma_request),
		.i_address (dma_address),
		.o_ready   (dma_ready),
		.o_rdata   (dma_rdata)
	);

	// Upper half of a bus word is the low address half plus one.
	function automatic logic [2*SW-1:0] expected_word(input logic [AW-1:0] address);
		expected_word = {address[SW-1:0] + SW'(1), address[SW-1:0]};
	endfunction

	assign beat        = dma_request && dma_ready;
	assign replace_now = setup_request && (setup_mode == MODE_REPLACE) && (setup_count != '0);

	// Each edge handles the output pop first, then the beat, then the setup pulse.
	always @(posedge clock or negedge arst_n) begin : reference_model
		command_t        head;
		command_t        incoming;
		logic [2*SW-1:0] word;
		logic [2*SW-1:0] played;
		if (!arst_n) begin
			cmd_q.delete();
			pair_q.delete();
			cur_format         = FORMAT_MONO;
			cur_address        = '0;
			cur_count          = '0;
			toggle_delay       <= '0;
			sample_level       <= 1'b0;
			output_due         <= 1'b0;
			expect_left        <= '0;
			expect_right       <= '0;
			model_busy         <= 1'b0;
			model_next_address <= '0;
		end else begin
			// Output register loads two edges after the toggle is seen.
			if (toggle_delay[1]) begin
				if (pair_q.size() != 0) begin
					played = pair_q.pop_front();
					expect_left  <= played[2*SW-1:SW];
					expect_right <= played[SW-1:0];
					pairs_played++;
				end else begin
					expect_left  <= '0;
					expect_right <= '0;
					underruns++;
				end
			end
			output_due   <= toggle_delay[1];
			toggle_delay <= {toggle_delay[0], (sample_clock != sample_level)};
			sample_level <= sample_clock;

			if (beat) begin
				beats++;
				if ((cur_count == '0) && (cmd_q.size() != 0)) begin
					head        = cmd_q.pop_front();
					cur_format  = head.format;
					cur_address = head.address;
					cur_count   = head.count;
				end
				if (cur_count != '0) begin
					word = expected_word(cur_address);
					if (cur_format == FORMAT_STEREO) begin
						pair_q.push_back(word);
						cur_count = cur_count - CW'(1);
					end else if (cur_count > CW'(1)) begin
						pair_q.push_back({word[SW-1:0], word[SW-1:0]});
						pair_q.push_back({word[2*SW-1:SW], word[2*SW-1:SW]});
						cur_count = cur_count - CW'(2);
					end else begin
						// Odd mono tail.
						pair_q.push_back({word[SW-1:0], word[SW-1:0]});
						cur_count = cur_count - CW'(1);
					end
					cur_address = cur_address + AW'(4);
				end
			end

			if (setup_request && (setup_count != '0)) begin
				if (setup_mode == MODE_REPLACE) begin
					cmd_q.delete();
					cur_count = '0;
				end
				incoming.format  = setup_format;
				incoming.address = setup_address;
				incoming.count   = setup_count;
				cmd_q.push_back(incoming);
			end

			model_busy         <= (cmd_q.size() != 0) || (cur_count != '0);
			model_next_address <= (cur_count != '0) ? cur_address :
				((cmd_q.size() != 0) ? cmd_q[0].address : '0);
		end
	end

	a_left: assert property (@(posedge clock) disable iff (!arst_n)
		output_due |-> (sample_left == expect_left))
		else begin
			$display("Mismatch o_sample_left: got %h, expected %h",
				$sampled(sample_left), $sampled(expect_left));
			error_count++;
		end

	a_right: assert property (@(posedge clock) disable iff (!arst_n)
		output_due |-> (sample_right == expect_right))
		else begin
			$display("Mismatch o_sample_right: got %h, expected %h",
				$sampled(sample_right), $sampled(expect_right));
			error_count++;
		end

	a_busy: assert property (@(posedge clock) disable iff (!arst_n)
		busy == model_busy)
		else begin
			$display("Mismatch o_busy: got %h, expected %h",
				$sampled(busy), $sampled(model_busy));
			error_count++;
		end

	a_beat_address: assert property (@(posedge clock) disable iff (!arst_n)
		beat |-> (dma_address == model_next_address))
		else begin
			$display("Mismatch o_dma_address: got %h, expected %h",
				$sampled(dma_address), $sampled(model_next_address));
			error_count++;
		end

	a_beat_expected: assert property (@(posedge clock) disable iff (!arst_n)
		beat |-> model_busy)
		else begin
			$display("A DMA beat was accepted with no transfer outstanding");
			error_count++;
		end

	a_request_hold: assert property (@(posedge clock) disable iff (!arst_n)
		(dma_request && !dma_ready && !replace_now)
			|=> (dma_request && $stable(dma_address)))
		else begin
			$display("A DMA request was dropped or its address moved before ready");
			error_count++;
		end

	a_idle_quiet: assert property (@(posedge clock) disable iff (!arst_n)
		!busy |-> !dma_request)
		else begin
			$display("A DMA request was raised while the channel was not busy");
			error_count++;
		end

	// Caller sits at a falling edge.
	task automatic issue_command(input setup_mode_e mode, input sample_format_e format,
			input logic [AW-1:0] address, input logic [CW-1:0] count);
		setup_request = 1'b1;
		setup_mode    = mode;
		setup_format  = format;
		setup_address = address;
		setup_count   = count;
		@(negedge clock);
		setup_request = 1'b0;
	endtask

	task automatic wait_playback();
		while (busy || (pair_q.size() != 0))
			@(negedge clock);
		// The last check lands one cycle after the final pop.
		repeat (2) @(negedge clock);
	endtask

	task automatic wait_underruns(input int count);
		int target;
		target = underruns + count;
		while (underruns < target)
			@(negedge clock);
		repeat (2) @(negedge clock);
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("Test %0d %s: %0d errors", tests_run, name, error_count - errors_at_start);
		errors_at_start = error_count;
	endtask

	initial begin : clock_gen
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin : sample_clock_gen
		sample_clock = 1'b0;
		@(posedge arst_n);
		forever begin
			repeat (TOGGLE_CYCLES) @(negedge clock);
			sample_clock = ~sample_clock;
		end
	end

	initial begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial begin : main
		int beats_start;
		void'($urandom(13));
		arst_n        = 1'b0;
		setup_request = 1'b0;
		setup_mode    = MODE_APPEND;
		setup_format  = FORMAT_MONO;
		setup_address = '0;
		setup_count   = '0;
		repeat (RESET_CYCLES) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);

		issue_command(MODE_APPEND, FORMAT_STEREO, 32'h0001_0100, 24'd8);
		wait_playback();
		report_test("stereo playback");

		issue_command(MODE_APPEND, FORMAT_MONO, 32'h0000_2000, 24'd5);
		wait_playback();
		report_test("mono odd count");

		issue_command(MODE_APPEND, FORMAT_STEREO, 32'h0000_3000, 24'd4);
		issue_command(MODE_APPEND, FORMAT_MONO, 32'h0000_3800, 24'd6);
		wait_playback();
		report_test("append chaining");

		// Replace lands while a request is out.
		issue_command(MODE_APPEND, FORMAT_STEREO, 32'h0000_4000, 24'd16);
		beats_start = beats;
		while ((beats < beats_start + 5) || !dma_request)
			@(negedge clock);
		issue_command(MODE_REPLACE, FORMAT_MONO, 32'h0000_5000, 24'd7);
		wait_playback();
		report_test("replace");

		wait_underruns(2);
		report_test("underrun");

		issue_command(MODE_APPEND, FORMAT_STEREO, 32'h0000_0040, 24'd0);
		issue_command(MODE_APPEND, FORMAT_STEREO, 32'h0001_FFF4, 24'd5);
		issue_command(MODE_APPEND, FORMAT_MONO, 32'h0000_6000, 24'd4);
		wait_playback();
		report_test("bus protocol");

		$display("%0d tests, %0d pairs played, %0d underruns, %0d errors",
			tests_run, pairs_played, underruns, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog/audio_channel.sv ====
// ======================================================================
// One audio playback channel.
// Setup pulses queue DMA commands; the fetcher reads words over a
// simple request/ready bus and the output plays a pair per toggle
// of i_sample_clock. Addresses must be word-aligned.
// ======================================================================

`timescale 1ns/1ps

`include "audio_channel_settings.svh"

module audio_channel (
	input  logic                                i_clock,
	input  logic                                i_arst_n,
	input  logic                                i_setup_request,
	input  audio_channel_pkg::setup_mode_e      i_setup_mode,
	input  audio_channel_pkg::sample_format_e   i_setup_format,
	input  logic [`AUDIO_ADDR_WIDTH-1:0]        i_setup_address,
	input  logic [`AUDIO_COUNT_WIDTH-1:0]       i_setup_count,
	output logic                                o_dma_request,
	output logic [`AUDIO_ADDR_WIDTH-1:0]        o_dma_address,
	input  logic                                i_dma_ready,
	input  logic [2*`AUDIO_SAMPLE_WIDTH-1:0]    i_dma_rdata,
	output logic                                o_busy,
	input  logic                                i_sample_clock,
	output logic [`AUDIO_SAMPLE_WIDTH-1:0]      o_sample_left,
	output logic [`AUDIO_SAMPLE_WIDTH-1:0]      o_sample_right
);
	import audio_channel_pkg::*;

	// Queue head.
	logic                           head_have;
	sample_format_e                 head_format;
	logic [`AUDIO_ADDR_WIDTH-1:0]   head_address;
	logic [`AUDIO_COUNT_WIDTH-1:0]  head_count;
	logic                           load_ready;
	logic                           abort;
	logic                           cmd_pending;

	// Fetcher to FIFO.
	logic                             write_one;
	logic                             write_two;
	logic [2*`AUDIO_SAMPLE_WIDTH-1:0] pair_first;
	logic [2*`AUDIO_SAMPLE_WIDTH-1:0] pair_second;
	logic                             fifo_room;
	logic                             fetch_active;

	// FIFO to output.
	logic                           fifo_not_empty;
	logic [`AUDIO_SAMPLE_WIDTH-1:0] head_left;
	logic [`AUDIO_SAMPLE_WIDTH-1:0] head_right;
	logic                           pop;

	audio_cmd_queue u_cmd_queue (
		.i_clock         (i_clock),
		.i_arst_n        (i_arst_n),
		.i_setup_request (i_setup_request),
		.i_setup_mode    (i_setup_mode),
		.i_setup_format  (i_setup_format),
		.i_setup_address (i_setup_address),
		.i_setup_count   (i_setup_count),
		.i_load_ready    (load_ready),
		.o_have          (head_have),
		.o_format        (head_format),
		.o_address       (head_address),
		.o_count         (head_count),
		.o_abort         (abort),
		.o_pending       (cmd_pending)
	);

	audio_sample_fetcher u_fetcher (
		.i_clock       (i_clock),
		.i_arst_n      (i_arst_n),
		.i_have        (head_have),
		.i_format      (head_format),
		.i_address     (head_address),
		.i_count       (head_count),
		.i_abort       (abort),
		.o_load_ready  (load_ready),
		.i_fifo_room   (fifo_room),
		.o_dma_request (o_dma_request),
		.o_dma_address (o_dma_address),
		.i_dma_ready   (i_dma_ready),
		.i_dma_rdata   (i_dma_rdata),
		.o_write_one   (write_one),
		.o_write_two   (write_two),
		.o_pair_first  (pair_first),
		.o_pair_second (pair_second),
		.o_active      (fetch_active)
	);

	audio_sample_fifo u_sample_fifo (
		.i_clock       (i_clock),
		.i_arst_n      (i_arst_n),
		.i_write_one   (write_one),
		.i_write_two   (write_two),
		.i_pair_first  (pair_first),
		.i_pair_second (pair_second),
		.o_room        (fifo_room),
		.i_pop         (pop),
		.o_not_empty   (fifo_not_empty),
		.o_head_left   (head_left),
		.o_head_right  (head_right)
	);

	audio_sample_output u_sample_output (
		.i_clock        (i_clock),
		.i_arst_n       (i_arst_n),
		.i_sample_clock (i_sample_clock),
		.i_not_empty    (fifo_not_empty),
		.i_head_left    (head_left),
		.i_head_right   (head_right),
		.o_pop          (pop),
		.o_sample_left  (o_sample_left),
		.o_sample_right (o_sample_right)
	);

	// Busy until the last word of the last command has been fetched.
	assign o_busy = cmd_pending || fetch_active;

endmodule

// ==== verilog/audio_channel_pkg.sv ====
// ======================================================================
// Enumerated types shared by the audio playback channel.
// Every enum is a packed logic type so it can cross module ports
// without casts. Widths here are fixed by the encodings below.
// ======================================================================

package audio_channel_pkg;

	// Layout of the 32-bit words fetched for a command.
	// Mono packs two samples per word, low half first.
	// Stereo packs one pair, left in the upper half.
	typedef enum logic {
		FORMAT_MONO   = 1'b0,
		FORMAT_STEREO = 1'b1
	} sample_format_e;

	// How a new command relates to the ones already queued.
	typedef enum logic {
		MODE_APPEND  = 1'b0,
		MODE_REPLACE = 1'b1
	} setup_mode_e;

	// Fetcher FSM.
	// Idle waits for a command or for FIFO room.
	// Request holds the bus request until ready.
	// Settle gives the FIFO one cycle to report its new level.
	typedef enum logic [1:0] {
		FETCH_IDLE    = 2'd0,
		FETCH_REQUEST = 2'd1,
		FETCH_SETTLE  = 2'd2
	} fetch_state_e;

endpackage

// ==== verilog/audio_channel_settings.svh ====
// ======================================================================
// Widths and depths of the audio playback channel.
// A bus word carries exactly two samples, so the data bus is twice
// AUDIO_SAMPLE_WIDTH. AUDIO_FIFO_DEPTH must be a power of two, >= 4.
// ======================================================================

`ifndef AUDIO_CHANNEL_SETTINGS_SVH
`define AUDIO_CHANNEL_SETTINGS_SVH

// Byte address of the bus master.
`define AUDIO_ADDR_WIDTH 32

// Sample count of one DMA command.
`define AUDIO_COUNT_WIDTH 24

// One channel of one sample.
`define AUDIO_SAMPLE_WIDTH 16

// Commands that can wait in the queue.
`define AUDIO_CMDQ_DEPTH 2

// Left/right pairs held between fetcher and output.
`define AUDIO_FIFO_DEPTH 4

`endif

// ==== verilog/audio_cmd_queue.sv ====
// ======================================================================
// In-order queue of DMA commands.
// Zero counts are ignored and appends to a full queue are dropped.
// A replace flushes the queue, stores itself and aborts the fetcher
// in the same cycle. A new entry reaches the head one cycle later.
// ======================================================================

`timescale 1ns/1ps

`include "audio_channel_settings.svh"

module audio_cmd_queue (
	input  logic                                i_clock,
	input  logic                                i_arst_n,
	input  logic                                i_setup_request,
	input  audio_channel_pkg::setup_mode_e      i_setup_mode,
	input  audio_channel_pkg::sample_format_e   i_setup_format,
	input  logic [`AUDIO_ADDR_WIDTH-1:0]        i_setup_address,
	input  logic [`AUDIO_COUNT_WIDTH-1:0]       i_setup_count,
	input  logic                                i_load_ready,
	output logic                                o_have,
	output audio_channel_pkg::sample_format_e   o_format,
	output logic [`AUDIO_ADDR_WIDTH-1:0]        o_address,
	output logic [`AUDIO_COUNT_WIDTH-1:0]       o_count,
	output logic                                o_abort,
	output logic                                o_pending
);
	import audio_channel_pkg::*;

	localparam int DEPTH  = `AUDIO_CMDQ_DEPTH;
	localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int USED_W = $clog2(DEPTH + 1);

	sample_format_e                 cmd_format  [DEPTH];
	logic [`AUDIO_ADDR_WIDTH-1:0]   cmd_address [DEPTH];
	logic [`AUDIO_COUNT_WIDTH-1:0]  cmd_count   [DEPTH];

	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W-1:0]  wr_ptr;
	logic [USED_W-1:0] used;

	logic take;
	logic do_replace;
	logic do_append;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
	endfunction

	assign take       = i_setup_request && (i_setup_count != '0);
	assign do_replace = take && (i_setup_mode == MODE_REPLACE);
	assign do_append  = take && (i_setup_mode == MODE_APPEND) && (used != USED_W'(DEPTH));
	assign do_pop     = o_have && i_load_ready;

	// Replace restarts the queue at slot zero, so a pop in the same cycle is moot.
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			used   <= '0;
		end else if (do_replace) begin
			rd_ptr <= '0;
			wr_ptr <= next_ptr('0);
			used   <= USED_W'(1);
		end else begin
			if (do_append)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			used <= used + USED_W'(do_append) - USED_W'(do_pop);
		end
	end

	// Command storage.
	always_ff @(posedge i_clock) begin
		if (do_replace || do_append) begin
			cmd_format[do_replace ? '0 : wr_ptr]  <= i_setup_format;
			cmd_address[do_replace ? '0 : wr_ptr] <= i_setup_address;
			cmd_count[do_replace ? '0 : wr_ptr]   <= i_setup_count;
		end
	end

	assign o_pending = (used != '0);
	assign o_have    = o_pending;
	assign o_format  = cmd_format[rd_ptr];
	assign o_address = cmd_address[rd_ptr];
	assign o_count   = cmd_count[rd_ptr];
	assign o_abort   = do_replace;

	// The fetcher treats a loaded zero count as finished at once.
	a_head_nonzero: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_have |-> (o_count != '0))
		else $error("Queue head has a zero count");

endmodule

// ==== verilog/audio_sample_fetcher.sv ====
// ======================================================================
// DMA bus master that reads 32-bit words and unpacks sample pairs.
// Request and address hold until i_dma_ready; rdata is taken in that
// cycle. A request is only raised while the FIFO has room for two.
// A beat accepted in the same cycle as an abort is still written.
// ======================================================================

`timescale 1ns/1ps

`include "audio_channel_settings.svh"

module audio_sample_fetcher (
	input  logic                                i_clock,
	input  logic                                i_arst_n,
	input  logic                                i_have,
	input  audio_channel_pkg::sample_format_e   i_format,
	input  logic [`AUDIO_ADDR_WIDTH-1:0]        i_address,
	input  logic [`AUDIO_COUNT_WIDTH-1:0]       i_count,
	input  logic                                i_abort,
	output logic                                o_load_ready,
	input  logic                                i_fifo_room,
	output logic                                o_dma_request,
	output logic [`AUDIO_ADDR_WIDTH-1:0]        o_dma_address,
	input  logic                                i_dma_ready,
	input  logic [2*`AUDIO_SAMPLE_WIDTH-1:0]    i_dma_rdata,
	output logic                                o_write_one,
	output logic                                o_write_two,
	output logic [2*`AUDIO_SAMPLE_WIDTH-1:0]    o_pair_first,
	output logic [2*`AUDIO_SAMPLE_WIDTH-1:0]    o_pair_second,
	output logic                                o_active
);
	import audio_channel_pkg::*;

	localparam int SW = `AUDIO_SAMPLE_WIDTH;
	localparam int CW = `AUDIO_COUNT_WIDTH;

	fetch_state_e           state;
	sample_format_e         format;
	logic [CW-1:0]          count;
	logic [CW-1:0]          count_after_beat;
	logic [`AUDIO_ADDR_WIDTH-1:0] address;
	logic [SW-1:0]          word_low;
	logic [SW-1:0]          word_high;
	logic                   beat;
	logic                   load;

	assign o_load_ready  = (state == FETCH_IDLE) && (count == '0);
	assign load          = i_have && o_load_ready && !i_abort;
	assign o_dma_request = (state == FETCH_REQUEST);
	assign o_dma_address = address;
	assign beat          = o_dma_request && i_dma_ready;
	assign o_active      = (count != '0);

	assign word_low  = i_dma_rdata[SW-1:0];
	assign word_high = i_dma_rdata[2*SW-1:SW];

	// Unpack the beat straight into the FIFO write ports.
	always_comb begin
		o_write_one      = 1'b0;
		o_write_two      = 1'b0;
		o_pair_first     = {word_low, word_low};
		o_pair_second    = {word_high, word_high};
		count_after_beat = count - CW'(1);
		if (format == FORMAT_STEREO) begin
			o_pair_first = i_dma_rdata;
			o_write_one  = beat;
		end else if (count > CW'(1)) begin
			o_write_two      = beat;
			count_after_beat = count - CW'(2);
		end else begin
			// Odd tail plays only the low half.
			o_write_one = beat;
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= FETCH_IDLE;
			count <= '0;
		end else if (i_abort) begin
			state <= FETCH_IDLE;
			count <= '0;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (load) begin
						count <= i_count;
						state <= i_fifo_room ? FETCH_REQUEST : FETCH_IDLE;
					end else if ((count != '0) && i_fifo_room) begin
						state <= FETCH_REQUEST;
					end
				end
				FETCH_REQUEST: begin
					if (i_dma_ready) begin
						count <= count_after_beat;
						state <= FETCH_SETTLE;
					end
				end
				FETCH_SETTLE: begin
					// Room now reflects the write of the last beat.
					state <= ((count != '0) && i_fifo_room) ? FETCH_REQUEST : FETCH_IDLE;
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (load) begin
			format  <= i_format;
			address <= i_address;
		end else if (beat) begin
			address <= address + `AUDIO_ADDR_WIDTH'(4);
		end
	end

	a_request_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(o_dma_request && !i_dma_ready && !i_abort)
			|=> (o_dma_request && $stable(o_dma_address)))
		else $error("DMA request dropped or address changed before ready");

endmodule

// ==== verilog/audio_sample_fifo.sv ====
// ======================================================================
// Circular buffer of left/right pairs, left in the upper half.
// Takes one or two pairs and gives one pair per cycle, both at once.
// o_room means at least two free slots.
// AUDIO_FIFO_DEPTH must be a power of two so the pointers wrap freely.
// ======================================================================

`timescale 1ns/1ps

`include "audio_channel_settings.svh"

module audio_sample_fifo (
	input  logic                             i_clock,
	input  logic                             i_arst_n,
	input  logic                             i_write_one,
	input  logic                             i_write_two,
	input  logic [2*`AUDIO_SAMPLE_WIDTH-1:0] i_pair_first,
	input  logic [2*`AUDIO_SAMPLE_WIDTH-1:0] i_pair_second,
	output logic                             o_room,
	input  logic                             i_pop,
	output logic                             o_not_empty,
	output logic [`AUDIO_SAMPLE_WIDTH-1:0]   o_head_left,
	output logic [`AUDIO_SAMPLE_WIDTH-1:0]   o_head_right
);
	localparam int DEPTH  = `AUDIO_FIFO_DEPTH;
	localparam int SW     = `AUDIO_SAMPLE_WIDTH;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int USED_W = PTR_W + 1;

	logic [2*SW-1:0]   mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [USED_W-1:0] used;
	logic [1:0]        write_count;

	assign write_count = i_write_two ? 2'd2 : {1'b0, i_write_one};

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			wr_ptr <= wr_ptr + PTR_W'(write_count);
			rd_ptr <= rd_ptr + PTR_W'(i_pop);
			used   <= used + USED_W'(write_count) - USED_W'(i_pop);
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_write_one || i_write_two)
			mem[wr_ptr] <= i_pair_first;
		if (i_write_two)
			mem[wr_ptr + PTR_W'(1)] <= i_pair_second;
	end

	assign o_room       = (used <= USED_W'(DEPTH - 2));
	assign o_not_empty  = (used != '0);
	assign o_head_left  = mem[rd_ptr][2*SW-1:SW];
	assign o_head_right = mem[rd_ptr][SW-1:0];

	// The fetcher checked room before its request went out.
	a_write_room: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(i_write_one || i_write_two) |-> o_room)
		else $error("Sample FIFO written without room");

	a_pop_not_empty: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_pop |-> o_not_empty)
		else $error("Sample FIFO popped while empty");

endmodule

// ==== verilog/audio_sample_output.sv ====
// ======================================================================
// Plays one sample pair per edge of the external sample clock.
// Both edges count. The outputs change 3 cycles after a toggle.
// An empty FIFO at an edge gives zeros. Hold the sample clock low
// through reset, or the first cycles see a false edge.
// ======================================================================

`timescale 1ns/1ps

`include "audio_channel_settings.svh"

module audio_sample_output (
	input  logic                           i_clock,
	input  logic                           i_arst_n,
	input  logic                           i_sample_clock,
	input  logic                           i_not_empty,
	input  logic [`AUDIO_SAMPLE_WIDTH-1:0] i_head_left,
	input  logic [`AUDIO_SAMPLE_WIDTH-1:0] i_head_right,
	output logic                           o_pop,
	output logic [`AUDIO_SAMPLE_WIDTH-1:0] o_sample_left,
	output logic [`AUDIO_SAMPLE_WIDTH-1:0] o_sample_right
);
	logic [1:0] sample_sync;
	logic       sample_last;
	logic       sample_edge;

	// Synchronized level against its previous value.
	assign sample_edge = sample_sync[1] ^ sample_last;
	assign o_pop       = sample_edge && i_not_empty;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sample_sync    <= '0;
			sample_last    <= 1'b0;
			o_sample_left  <= '0;
			o_sample_right <= '0;
		end else begin
			sample_sync <= {sample_sync[0], i_sample_clock};
			sample_last <= sample_sync[1];
			if (sample_edge) begin
				// Underrun plays silence.
				o_sample_left  <= i_not_empty ? i_head_left : '0;
				o_sample_right <= i_not_empty ? i_head_right : '0;
			end
		end
	end

endmodule
